// File: build.f
src/motion_pkg.sv
src/fifo_command_reader.sv
src/move_planner.sv
src/stepper_pulse_gen.sv
src/response_writer.sv
src/motion_bridge_top.sv
bench/tb_hps_fifos.sv
bench/motion_bridge_tb.sv

// File: Makefile
# Verilator flow for the motion bridge testbench

TOP := motion_bridge_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: bench/motion_bridge_tb.sv
// Moves must finish inside the watchdog budget; pulse timing measured in whole CLOCK_50 cycles
`default_nettype none

module motion_bridge_tb;

	localparam int STEP_BASE  = 8;
	localparam int PULSE_HIGH = 2;
	localparam int WAIT_LIMIT = 100;
	// Steps times largest interval for each move, then 200 cycles per command
	localparam int MOVE_CYCLES     = 12 * 19 + 40 * 32 + 40 * 8 + 16 * 32;
	localparam int CMD_COUNT       = 9;
	localparam int WATCHDOG_CYCLES = 10 + MOVE_CYCLES + 200 * CMD_COUNT;

	logic                     CLOCK_50;
	logic                     rst_n;
	logic                     in_push;
	motion_pkg::fifo_word_t   in_data;
	logic                     h2f_read;
	motion_pkg::fifo_word_t   h2f_readdata;
	motion_pkg::fill_level_t  h2f_fill_level;
	logic                     f2h_write;
	motion_pkg::fifo_word_t   f2h_writedata;
	logic                     hold_full;
	logic                     f2h_full;
	logic                     out_pop;
	motion_pkg::fifo_word_t   out_head;
	int                       out_count;
	motion_pkg::step_divide_t step_divide;
	logic                     equal_speed;
	logic                     step1;
	logic                     dir1;
	logic                     step2;
	logic                     dir2;

	// Pulse monitor results, index 0 is joint1
	logic                     stats_clear;
	int                       cycle;
	int                       edges[2];
	int                       last_edge[2];
	int                       gap_min[2];
	int                       gap_max[2];
	bit                       dir_first[2];
	bit                       dir_mixed[2];
	bit [1:0]                 prev_step;
	bit                       writes_seen;

	int                       tests;
	int                       checks;
	int                       errors;
	int unsigned              seed;

	motion_bridge_top #(
		.STEP_BASE_CYCLES(STEP_BASE), .PULSE_HIGH_CYCLES(PULSE_HIGH)
	) u_motion_bridge_top (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n),
		.h2f_readdata(h2f_readdata), .h2f_fill_level(h2f_fill_level), .h2f_read(h2f_read),
		.f2h_writedata(f2h_writedata), .f2h_write(f2h_write), .f2h_full(f2h_full),
		.step_divide(step_divide), .equal_speed(equal_speed),
		.step1(step1), .dir1(dir1), .step2(step2), .dir2(dir2)
	);

	tb_hps_fifos u_hps_fifos (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .in_push(in_push), .in_data(in_data),
		.h2f_read(h2f_read), .h2f_readdata(h2f_readdata), .h2f_fill_level(h2f_fill_level),
		.f2h_write(f2h_write), .f2h_writedata(f2h_writedata), .hold_full(hold_full),
		.f2h_full(f2h_full), .out_pop(out_pop), .out_head(out_head), .out_count(out_count)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	// ================================================
	// Step pulse monitor
	// ================================================
	always @(posedge CLOCK_50) begin
		bit [1:0] steps;
		bit [1:0] dirs;
		steps = {step2, step1};
		dirs  = {dir2, dir1};
		cycle = cycle + 1;
		if (stats_clear) begin
			for (int j = 0; j < 2; j++) begin
				edges[j]     = 0;
				gap_min[j]   = 1 << 30;
				gap_max[j]   = 0;
				dir_mixed[j] = 1'b0;
			end
			writes_seen = 1'b0;
		end else begin
			for (int j = 0; j < 2; j++) begin
				if (steps[j] && !prev_step[j]) begin
					if (edges[j] == 0) begin
						dir_first[j] = dirs[j];
					end else begin
						// Rising edge to rising edge
						gap_min[j] = (cycle - last_edge[j] < gap_min[j]) ? cycle - last_edge[j] : gap_min[j];
						gap_max[j] = (cycle - last_edge[j] > gap_max[j]) ? cycle - last_edge[j] : gap_max[j];
					end
					edges[j]     = edges[j] + 1;
					last_edge[j] = cycle;
				end
				// dir must hold for the whole pulse
				if (steps[j] && dirs[j] != dir_first[j]) begin
					dir_mixed[j] = 1'b1;
				end
			end
			if (f2h_write) begin
				writes_seen = 1'b1;
			end
		end
		prev_step = steps;
	end

	// ================================================
	// Compare tasks
	// ================================================
	task automatic check_word(input string name, input motion_pkg::fifo_word_t exp,
		input motion_pkg::fifo_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input motion_pkg::step_count_t exp,
		input motion_pkg::step_count_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_fill(input string name, input motion_pkg::fill_level_t exp,
		input motion_pkg::fill_level_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	// Pulse spacing in clocks
	task automatic check_interval(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	// ================================================
	// Stimulus helpers
	// ================================================
	task automatic next_cycle();
		@(posedge CLOCK_50);
		#1;
	endtask

	task automatic push_word(input motion_pkg::fifo_word_t w);
		in_data = w;
		in_push = 1'b1;
		next_cycle();
		in_push = 1'b0;
	endtask

	task automatic clear_stats();
		stats_clear = 1'b1;
		next_cycle();
		stats_clear = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("%s: %s", name, (errors == errors_before) ? "ok" : "errors");
	endtask

	// Random word with any code but a move
	function automatic motion_pkg::fifo_word_t random_noop();
		motion_pkg::fifo_word_t w;
		motion_pkg::cmd_code_t  code;
		w = $urandom;
		do begin
			code = motion_pkg::cmd_code_t'($urandom);
		end while (code == motion_pkg::CMD_MOVE);
		w[motion_pkg::CMD_LSB +: 4] = code;
		return w;
	endfunction

	function automatic motion_pkg::fifo_word_t make_move(input motion_pkg::step_count_t c1,
		input logic d1, input motion_pkg::step_count_t c2, input logic d2);
		motion_pkg::fifo_word_t w;
		w = '0;
		w[motion_pkg::CMD_LSB +: 4]                  = motion_pkg::CMD_MOVE;
		w[motion_pkg::X_LSB +: 8]                    = c1;
		w[motion_pkg::X_LSB + motion_pkg::AXIS_DIR_BIT] = d1;
		w[motion_pkg::Y_LSB +: 8]                    = c2;
		w[motion_pkg::Y_LSB + motion_pkg::AXIS_DIR_BIT] = d2;
		return w;
	endfunction

	// Shorter joint stretched by the floor of the 8.8 count ratio
	function automatic int joint_scale(input int own, input int other, input logic eq);
		if (eq || own == 0 || other == 0 || own >= other) begin
			return 256;
		end
		return (other * 256) / own;
	endfunction

	function automatic int joint_interval(input int divide, input int scale);
		return ((STEP_BASE << divide) * scale) >> 8;
	endfunction

	// Pops one echo and compares it, with a timeout
	task automatic wait_echo(input string name, input motion_pkg::fifo_word_t exp);
		for (int i = 0; i < WAIT_LIMIT; i++) begin
			@(negedge CLOCK_50);
			if (out_count != 0) begin
				break;
			end
		end
		if (out_count == 0) begin
			errors++;
			$display("%s never reached the outbound FIFO", name);
		end else begin
			check_word(name, exp, out_head);
			next_cycle();
			out_pop = 1'b1;
			next_cycle();
			out_pop = 1'b0;
		end
	endtask

	task automatic run_move(input string label, input int c1, input logic d1, input int c2,
		input logic d2, input int divide, input logic eq, input bit check_gaps);
		motion_pkg::fifo_word_t w;
		int                     ivl1;
		int                     ivl2;
		w           = make_move(8'(c1), d1, 8'(c2), d2);
		step_divide = 3'(divide);
		equal_speed = eq;
		clear_stats();
		push_word(w);
		wait_echo({label, " echo"}, w);
		ivl1 = joint_interval(divide, joint_scale(c1, c2, eq));
		ivl2 = joint_interval(divide, joint_scale(c2, c1, eq));
		for (int i = 0; i < WAIT_LIMIT + (c1 + c2) * (ivl1 + ivl2); i++) begin
			if (edges[0] >= c1 && edges[1] >= c2) begin
				break;
			end
			@(negedge CLOCK_50);
		end
		if (edges[0] < c1 || edges[1] < c2) begin
			errors++;
			$display("%s did not finish its step pulses", label);
		end
		// Room for any extra pulse to show up
		repeat (((ivl1 > ivl2) ? ivl1 : ivl2) + 10) @(negedge CLOCK_50);
		check_count({label, " step1 pulses"}, 8'(c1), 8'(edges[0]));
		check_count({label, " step2 pulses"}, 8'(c2), 8'(edges[1]));
		if (c1 != 0) begin
			check_level({label, " dir1"}, d1, dir_first[0]);
			check_level({label, " dir1 steady"}, 1'b0, dir_mixed[0]);
		end
		if (c2 != 0) begin
			check_level({label, " dir2"}, d2, dir_first[1]);
			check_level({label, " dir2 steady"}, 1'b0, dir_mixed[1]);
		end
		if (check_gaps && c1 > 1) begin
			check_interval({label, " step1 min gap"}, ivl1, gap_min[0]);
			check_interval({label, " step1 max gap"}, ivl1, gap_max[0]);
		end
		if (check_gaps && c2 > 1) begin
			check_interval({label, " step2 min gap"}, ivl2, gap_min[1]);
			check_interval({label, " step2 max gap"}, ivl2, gap_max[1]);
		end
		next_cycle();
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic test_idle_after_reset();
		int e;
		e = errors;
		repeat (20) begin
			@(negedge CLOCK_50);
			check_level("step1 idle", 1'b0, step1);
			check_level("step2 idle", 1'b0, step2);
			check_level("h2f_read idle", 1'b0, h2f_read);
			check_level("f2h_write idle", 1'b0, f2h_write);
		end
		next_cycle();
		finish_test("idle after reset", e);
	endtask

	task automatic test_noop_echo();
		motion_pkg::fifo_word_t words[3];
		int                     e;
		e = errors;
		clear_stats();
		foreach (words[i]) begin
			words[i] = random_noop();
			push_word(words[i]);
		end
		foreach (words[i]) begin
			wait_echo($sformatf("no-op echo %0d", i), words[i]);
		end
		check_count("no-op step1 pulses", 8'd0, 8'(edges[0]));
		check_count("no-op step2 pulses", 8'd0, 8'(edges[1]));
		finish_test("no-op echo", e);
	endtask

	task automatic test_move_counts();
		int e;
		e = errors;
		run_move("move 12/5", 12, 1'b1, 5, 1'b0, 0, 1'b0, 1'b0);
		finish_test("move counts and directions", e);
	endtask

	task automatic test_move_ratio();
		int e;
		e = errors;
		run_move("move 40/10", 40, 1'b0, 10, 1'b1, 0, 1'b0, 1'b1);
		run_move("move 40/10 equal", 40, 1'b1, 10, 1'b0, 0, 1'b1, 1'b1);
		equal_speed = 1'b0;
		finish_test("move speed ratio", e);
	endtask

	task automatic test_divide_zero_count();
		int e;
		e = errors;
		run_move("move 0/16 divide 2", 0, 1'b0, 16, 1'b1, 2, 1'b0, 1'b1);
		step_divide = '0;
		finish_test("step divide with idle joint", e);
	endtask

	task automatic test_back_pressure();
		motion_pkg::fifo_word_t w1;
		motion_pkg::fifo_word_t w2;
		int                     e;
		e         = errors;
		w1        = random_noop();
		w2        = random_noop();
		hold_full = 1'b1;
		clear_stats();
		push_word(w1);
		push_word(w2);
		// Reader stalls behind the held echo
		repeat (40) @(negedge CLOCK_50);
		check_level("f2h_write while full", 1'b0, writes_seen);
		check_fill("h2f_fill_level while full", 32'd1, h2f_fill_level);
		next_cycle();
		hold_full = 1'b0;
		wait_echo("held echo 1", w1);
		wait_echo("held echo 2", w2);
		finish_test("outbound back-pressure", e);
	endtask

	// ================================================
	// Run control
	// ================================================
	initial begin
		seed        = $urandom(32'h66da_1519);
		rst_n       = 1'b0;
		in_push     = 1'b0;
		in_data     = '0;
		hold_full   = 1'b0;
		out_pop     = 1'b0;
		step_divide = '0;
		equal_speed = 1'b0;
		stats_clear = 1'b0;
		repeat (10) @(posedge CLOCK_50);
		#1;
		rst_n = 1'b1;
		test_idle_after_reset();
		test_noop_echo();
		test_move_counts();
		test_move_ratio();
		test_divide_zero_count();
		test_back_pressure();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
		$display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tb_hps_fifos.sv
// Unbounded inbound queue; outbound full when OUT_DEPTH words wait or hold_full is high
`default_nettype none

module tb_hps_fifos #(
	parameter int OUT_DEPTH = 8
) (
	input  wire logic                     CLOCK_50,
	input  wire logic                     rst_n,
	// Testbench side of the inbound FIFO
	input  wire logic                     in_push,
	input  wire motion_pkg::fifo_word_t   in_data,
	// DUT side of the inbound FIFO
	input  wire logic                     h2f_read,
	output motion_pkg::fifo_word_t        h2f_readdata,
	output motion_pkg::fill_level_t       h2f_fill_level,
	// DUT side of the outbound FIFO
	input  wire logic                     f2h_write,
	input  wire motion_pkg::fifo_word_t   f2h_writedata,
	input  wire logic                     hold_full,
	output logic                          f2h_full,
	// Testbench side of the outbound FIFO
	input  wire logic                     out_pop,
	output motion_pkg::fifo_word_t        out_head,
	output int                            out_count
);

	motion_pkg::fifo_word_t in_q[$];
	motion_pkg::fifo_word_t out_q[$];

	// Forced full for back-pressure tests
	assign f2h_full = hold_full || (out_count >= OUT_DEPTH);

	// ================================================
	// Both queues, status registered at the edge
	// ================================================
	always @(posedge CLOCK_50 or negedge rst_n) begin
		motion_pkg::fifo_word_t dropped;
		if (!rst_n) begin
			in_q.delete();
			out_q.delete();
			h2f_readdata   <= '0;
			h2f_fill_level <= '0;
			out_head       <= '0;
			out_count      <= 0;
		end else begin
			// Popped word shows from the next cycle and is held
			if (h2f_read && in_q.size() != 0) begin
				h2f_readdata <= in_q.pop_front();
			end
			if (in_push) begin
				in_q.push_back(in_data);
			end
			// Pop before push keeps order on a shared edge
			if (out_pop && out_q.size() != 0) begin
				dropped = out_q.pop_front();
			end
			if (f2h_write) begin
				out_q.push_back(f2h_writedata);
			end
			h2f_fill_level <= motion_pkg::fill_level_t'(in_q.size());
			out_count      <= out_q.size();
			out_head       <= (out_q.size() != 0) ? out_q[0] : '0;
		end
	end

endmodule

`default_nettype wire

// File: src/motion_bridge_top.sv
// Plain FIFO ports stand in for the HPS bridge; step timing assumes the 50 MHz CLOCK_50
`default_nettype none

module motion_bridge_top #(
	parameter int STEP_BASE_CYCLES  = 8,
	parameter int PULSE_HIGH_CYCLES = 2
) (
	input  wire logic                      CLOCK_50,
	input  wire logic                      rst_n,
	// Inbound FIFO
	input  wire motion_pkg::fifo_word_t    h2f_readdata,
	input  wire motion_pkg::fill_level_t   h2f_fill_level,
	output logic                           h2f_read,
	// Outbound FIFO
	output motion_pkg::fifo_word_t         f2h_writedata,
	output logic                           f2h_write,
	input  wire logic                      f2h_full,
	// Switches
	input  wire motion_pkg::step_divide_t  step_divide,
	input  wire logic                      equal_speed,
	// Stepper drivers
	output logic                           step1,
	output logic                           dir1,
	output logic                           step2,
	output logic                           dir2
);

	logic                    cmd_valid;
	motion_pkg::cmd_code_t   cmd;
	motion_pkg::axis_value_t x_value;
	motion_pkg::axis_value_t y_value;
	motion_pkg::fifo_word_t  raw_word;
	logic                    move_ready;
	logic                    resp_ready;
	logic                    start;
	motion_pkg::step_count_t num_steps1;
	motion_pkg::step_count_t num_steps2;
	logic                    dir_out1;
	logic                    dir_out2;
	motion_pkg::step_scale_t scale1;
	motion_pkg::step_scale_t scale2;
	logic                    busy1;
	logic                    busy2;

	// ================================================
	// Decode
	// ================================================
	fifo_command_reader u_fifo_command_reader (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n),
		.h2f_readdata(h2f_readdata), .h2f_fill_level(h2f_fill_level), .h2f_read(h2f_read),
		.move_ready(move_ready), .resp_ready(resp_ready),
		.cmd_valid(cmd_valid), .cmd(cmd), .x_value(x_value), .y_value(y_value),
		.raw_word(raw_word)
	);

	// Move setup for both joints
	move_planner u_move_planner (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd(cmd), .x_value(x_value), .y_value(y_value),
		.equal_speed(equal_speed), .busy1(busy1), .busy2(busy2),
		.move_ready(move_ready), .start(start),
		.num_steps1(num_steps1), .dir_out1(dir_out1), .scale1(scale1),
		.num_steps2(num_steps2), .dir_out2(dir_out2), .scale2(scale2)
	);

	stepper_pulse_gen #(
		.STEP_BASE_CYCLES(STEP_BASE_CYCLES), .PULSE_HIGH_CYCLES(PULSE_HIGH_CYCLES)
	) joint1 (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .start(start),
		.num_steps(num_steps1), .direction(dir_out1), .step_scale(scale1),
		.step_divide(step_divide), .step(step1), .dir(dir1), .busy(busy1)
	);

	stepper_pulse_gen #(
		.STEP_BASE_CYCLES(STEP_BASE_CYCLES), .PULSE_HIGH_CYCLES(PULSE_HIGH_CYCLES)
	) joint2 (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .start(start),
		.num_steps(num_steps2), .direction(dir_out2), .step_scale(scale2),
		.step_divide(step_divide), .step(step2), .dir(dir2), .busy(busy2)
	);

	// Echo back to the HPS
	response_writer u_response_writer (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .raw_word(raw_word), .f2h_full(f2h_full),
		.f2h_write(f2h_write), .f2h_writedata(f2h_writedata), .resp_ready(resp_ready)
	);

endmodule

`default_nettype wire

// File: src/response_writer.sv
// One-word echo slot; a new word must not arrive before the previous echo is written
`default_nettype none

module response_writer (
	input  wire logic                    CLOCK_50,
	input  wire logic                    rst_n,
	input  wire logic                    cmd_valid,
	input  wire motion_pkg::fifo_word_t  raw_word,
	input  wire logic                    f2h_full,
	output logic                         f2h_write,
	output motion_pkg::fifo_word_t       f2h_writedata,
	output logic                         resp_ready
);

	logic echo_valid;

	// ================================================
	// Echo slot
	// ================================================

	// Write as soon as there is room
	assign f2h_write  = echo_valid && !f2h_full;
	// Reader stalls while a word waits
	assign resp_ready = !echo_valid;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			echo_valid <= 1'b0;
		end else if (cmd_valid) begin
			echo_valid <= 1'b1;
		end else if (f2h_write) begin
			// Single write per word
			echo_valid <= 1'b0;
		end
	end

	// Word stays on the bus through back-pressure
	always_ff @(posedge CLOCK_50) begin
		if (cmd_valid) begin
			f2h_writedata <= raw_word;
		end
	end

	// New word only lands in an empty slot
	a_slot_free: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		cmd_valid |-> !echo_valid)
		else $error("echo slot overwritten");

endmodule

`default_nettype wire

// File: src/stepper_pulse_gen.sv
// Start is ignored while busy; interval is clamped to one clock above the high time
`default_nettype none

module stepper_pulse_gen #(
	parameter int STEP_BASE_CYCLES  = 8,
	parameter int PULSE_HIGH_CYCLES = 2
) (
	input  wire logic                      CLOCK_50,
	input  wire logic                      rst_n,
	input  wire logic                      start,
	input  wire motion_pkg::step_count_t   num_steps,
	input  wire logic                      direction,
	input  wire motion_pkg::step_scale_t   step_scale,
	input  wire motion_pkg::step_divide_t  step_divide,
	output logic                           step,
	output logic                           dir,
	output logic                           busy
);

	// Room for base << 7 times a full 8.8 scale
	localparam int IVL_W = 24;
	localparam logic [IVL_W-1:0] HIGH_LEN = IVL_W'(PULSE_HIGH_CYCLES);
	localparam logic [IVL_W-1:0] MIN_IVL  = HIGH_LEN + 1'b1;

	motion_pkg::pulse_state_t state;
	motion_pkg::step_count_t  remaining;
	logic [IVL_W-1:0]         cnt;
	logic [IVL_W-1:0]         interval;
	logic [IVL_W-1:0]         base_shift;
	logic [IVL_W+15:0]        product;
	logic [IVL_W-1:0]         next_interval;

	// Base interval, divided down, then stretched by the 8.8 scale
	assign base_shift    = IVL_W'(STEP_BASE_CYCLES) << step_divide;
	assign product       = base_shift * step_scale;
	assign next_interval = (product[IVL_W+7:8] < MIN_IVL) ? MIN_IVL : product[IVL_W+7:8];

	assign busy = (state != motion_pkg::PG_IDLE);

	// ================================================
	// Pulse FSM
	// ================================================
	// cnt counts clocks from each rising edge, starting at 1
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state     <= motion_pkg::PG_IDLE;
			step      <= 1'b0;
			dir       <= 1'b0;
			remaining <= '0;
			cnt       <= '0;
		end else begin
			case (state)
				motion_pkg::PG_IDLE: begin
					// Zero steps stays idle
					if (start && num_steps != '0) begin
						remaining <= num_steps;
						dir       <= direction;
						step      <= 1'b1;
						cnt       <= IVL_W'(1);
						state     <= motion_pkg::PG_HIGH;
					end
				end
				motion_pkg::PG_HIGH: begin
					cnt <= cnt + 1'b1;
					if (cnt >= HIGH_LEN) begin
						step  <= 1'b0;
						state <= motion_pkg::PG_LOW;
					end
				end
				motion_pkg::PG_LOW: begin
					if (cnt >= interval) begin
						// Last pulse keeps its full low time
						if (remaining == 8'd1) begin
							state <= motion_pkg::PG_IDLE;
						end else begin
							remaining <= remaining - 1'b1;
							step      <= 1'b1;
							cnt       <= IVL_W'(1);
							state     <= motion_pkg::PG_HIGH;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					step  <= 1'b0;
					state <= motion_pkg::PG_IDLE;
				end
			endcase
		end
	end

	// Interval for the whole move
	always_ff @(posedge CLOCK_50) begin
		if (start && state == motion_pkg::PG_IDLE) begin
			interval <= next_interval;
		end
	end

endmodule

`default_nettype wire

// File: src/move_planner.sv
// Step counts sit in bits 7..0 of each axis field; ratio truncates toward zero, no rounding
`default_nettype none

module move_planner (
	input  wire logic                     CLOCK_50,
	input  wire logic                     rst_n,
	input  wire logic                     cmd_valid,
	input  wire motion_pkg::cmd_code_t    cmd,
	input  wire motion_pkg::axis_value_t  x_value,
	input  wire motion_pkg::axis_value_t  y_value,
	input  wire logic                     equal_speed,
	input  wire logic                     busy1,
	input  wire logic                     busy2,
	output logic                          move_ready,
	output logic                          start,
	output motion_pkg::step_count_t       num_steps1,
	output logic                          dir_out1,
	output motion_pkg::step_scale_t       scale1,
	output motion_pkg::step_count_t       num_steps2,
	output logic                          dir_out2,
	output motion_pkg::step_scale_t       scale2
);

	localparam int CNT_W = $bits(motion_pkg::step_count_t);

	logic                    is_move;
	motion_pkg::step_count_t count1;
	motion_pkg::step_count_t count2;
	motion_pkg::step_scale_t next_scale1;
	motion_pkg::step_scale_t next_scale2;

	assign is_move = cmd_valid && (cmd == motion_pkg::CMD_MOVE);
	assign count1  = x_value[CNT_W-1:0];
	assign count2  = y_value[CNT_W-1:0];

	// Low from the move strobe until both joints are done
	assign move_ready = !is_move && !start && !busy1 && !busy2;

	// ================================================
	// Interval stretch for the shorter joint
	// ================================================
	always_comb begin
		next_scale1 = motion_pkg::SCALE_ONE;
		next_scale2 = motion_pkg::SCALE_ONE;
		if (equal_speed || count1 == '0 || count2 == '0) begin
			// Both at base rate
			next_scale1 = motion_pkg::SCALE_ONE;
			next_scale2 = motion_pkg::SCALE_ONE;
		end else if (count1 > count2) begin
			// Joint2 slows to finish with joint1
			next_scale2 = motion_pkg::step_scale_t'({count1, 8'd0} / count2);
		end else begin
			next_scale1 = motion_pkg::step_scale_t'({count2, 8'd0} / count1);
		end
	end

	// Start goes out one cycle after the move strobe
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
		end else begin
			start <= is_move;
		end
	end

	// Per-joint move arguments
	always_ff @(posedge CLOCK_50) begin
		if (is_move) begin
			num_steps1 <= count1;
			dir_out1   <= x_value[motion_pkg::AXIS_DIR_BIT];
			scale1     <= next_scale1;
			num_steps2 <= count2;
			dir_out2   <= y_value[motion_pkg::AXIS_DIR_BIT];
			scale2     <= next_scale2;
		end
	end

	// A start during a running move would be dropped by the generators
	a_start_idle: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		start |-> !(busy1 || busy2))
		else $error("start while a joint is busy");

endmodule

`default_nettype wire

// File: src/fifo_command_reader.sv
// Expects readdata valid from the cycle after the read pulse and held; one word in flight at a time
`default_nettype none

module fifo_command_reader (
	input  wire logic                     CLOCK_50,
	input  wire logic                     rst_n,
	input  wire motion_pkg::fifo_word_t   h2f_readdata,
	input  wire motion_pkg::fill_level_t  h2f_fill_level,
	output logic                          h2f_read,
	input  wire logic                     move_ready,
	input  wire logic                     resp_ready,
	output logic                          cmd_valid,
	output motion_pkg::cmd_code_t         cmd,
	output motion_pkg::axis_value_t       x_value,
	output motion_pkg::axis_value_t       y_value,
	output motion_pkg::fifo_word_t        raw_word
);

	motion_pkg::reader_state_t state;
	logic                      can_pop;

	// Data waiting and both consumers free
	// Blocked during cmd_valid since ready flags only drop a cycle later
	assign can_pop = (h2f_fill_level != '0) && move_ready && resp_ready && !cmd_valid;

	// ================================================
	// Control FSM
	// ================================================
	// Cycle 1 read pulse
	// Cycle 2 word on the bus, registered at its end
	// Cycle 4 cmd_valid
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state     <= motion_pkg::RD_AWAIT;
			h2f_read  <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			// Strobe only ever lasts one cycle
			cmd_valid <= 1'b0;
			case (state)
				motion_pkg::RD_AWAIT: begin
					if (can_pop) begin
						h2f_read <= 1'b1;
						state    <= motion_pkg::RD_POP;
					end
				end
				motion_pkg::RD_POP: begin
					// Drop the pop before the word shows up
					h2f_read <= 1'b0;
					state    <= motion_pkg::RD_CAPTURE;
				end
				motion_pkg::RD_CAPTURE: begin
					state <= motion_pkg::RD_DISPATCH;
				end
				motion_pkg::RD_DISPATCH: begin
					cmd_valid <= 1'b1;
					state     <= motion_pkg::RD_AWAIT;
				end
				default: begin
					h2f_read <= 1'b0;
					state    <= motion_pkg::RD_AWAIT;
				end
			endcase
		end
	end

	// Field split of the popped word
	// Held until the next capture
	always_ff @(posedge CLOCK_50) begin
		if (state == motion_pkg::RD_CAPTURE) begin
			raw_word <= h2f_readdata;
			cmd      <= h2f_readdata[motion_pkg::CMD_LSB +: $bits(motion_pkg::cmd_code_t)];
			x_value  <= h2f_readdata[motion_pkg::X_LSB +: $bits(motion_pkg::axis_value_t)];
			y_value  <= h2f_readdata[motion_pkg::Y_LSB +: $bits(motion_pkg::axis_value_t)];
		end
	end

endmodule

`default_nettype wire

// File: src/motion_pkg.sv
// Fixed 32-bit HPS FIFO command word; only 8-bit step counts, and only CMD_MOVE acts, other codes are echoed
`default_nettype none

package motion_pkg;

	// ================================================
	// Word and field widths
	// ================================================

	// Raw word on both HPS FIFOs
	typedef logic [31:0] fifo_word_t;
	// Live fill count of the inbound FIFO
	typedef logic [31:0] fill_level_t;
	typedef logic [3:0]  cmd_code_t;
	// x or y argument field
	typedef logic [13:0] axis_value_t;
	// Steps for one joint per move
	typedef logic [7:0]  step_count_t;
	// Interval stretch in 8.8 fixed point
	typedef logic [15:0] step_scale_t;
	// Slow-down exponent from the switches
	typedef logic [2:0]  step_divide_t;

	// ================================================
	// Command word layout
	// ================================================

	localparam int CMD_LSB      = 0;
	localparam int X_LSB        = 4;
	localparam int Y_LSB        = 18;
	// Direction flag inside an axis field
	localparam int AXIS_DIR_BIT = 13;

	// Only command that moves the joints
	localparam cmd_code_t   CMD_MOVE  = 4'd1;
	// Ratio of 1.0
	localparam step_scale_t SCALE_ONE = 16'd256;

	// Inbound FIFO reader
	typedef enum logic [1:0] {
		RD_AWAIT,
		RD_POP,
		RD_CAPTURE,
		RD_DISPATCH
	} reader_state_t;

	// Step pulse timing
	typedef enum logic [1:0] {
		PG_IDLE,
		PG_HIGH,
		PG_LOW
	} pulse_state_t;

endpackage

`default_nettype wire
